/* oob_downstream.f */
hw/stack_bus_pkg.sv
hw/oob_cmd_pkg.sv
hw/oob_cmd_queue.sv
hw/oob_packet_seq.sv
hw/oob_downstream_top.sv
bench/tb_clock.sv
bench/oob_downstream_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the OOB downstream testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module oob_downstream_tb \
  -Mdir obj_dir \
  -f oob_downstream.f

# The simulator status is ignored here; the log decides
./obj_dir/Voob_downstream_tb 2>&1 | tee sim.log

if grep -q "tests failed" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

/* bench/oob_downstream_tb.sv */
// Testbench for the OOB downstream controller.
// Sends commands from a decoder model, keeps a reference queue and
// checks the stack bus packets with concurrent assertions.

module oob_downstream_tb;

  localparam int N_SINGLE = 6;
  localparam int N_BURST  = 12;
  localparam int N_RANDOM = 20;
  localparam int N_TOTAL  = N_SINGLE + N_BURST + N_RANDOM + 1;
  localparam int WATCHDOG_CYCLES = N_TOTAL * 200 + 500;
  localparam logic [31:0] SEED = 32'h0c107645;

  logic                      clk;
  logic                      rst_n;
  logic                      cmd_valid;
  oob_cmd_pkg::oob_cmd_t     cmd;
  logic                      cmd_ready;
  logic                      oob_valid;
  stack_bus_pkg::oob_beat_t  oob;
  logic                      oob_ready;
  logic                      seq_error;

  // Reference state, only touched on the falling edge
  oob_cmd_pkg::oob_cmd_t     ref_q [$];
  oob_cmd_pkg::oob_cmd_t     exp_cmd;
  int                        pending;
  logic                      any_sent;
  logic                      bad_sent;
  logic                      reset_checked;
  logic                      prev_eom;
  logic                      saw_ready_low;
  stack_bus_pkg::oob_data_t  exp_first;
  stack_bus_pkg::oob_data_t  exp_second;
  logic                      som_beat;
  logic                      eom_beat;

  tb_clock #(.PERIOD(4)) u_clock (.clk(clk));

  oob_downstream_top uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .cmd_ready (cmd_ready),
    .oob_valid (oob_valid),
    .oob       (oob),
    .oob_ready (oob_ready),
    .seq_error (seq_error)
  );

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("tests failed");
    $fatal(1);
  endtask

  // ------------------------------------------------------------------
  // Expected beat contents
  // ------------------------------------------------------------------

  function automatic stack_bus_pkg::oob_data_t first_data(input oob_cmd_pkg::oob_cmd_t c);
    stack_bus_pkg::oob_data_t d;
    d.opt0   = stack_bus_pkg::STOP_CMD;
    d.value0 = c.stop_cmd;
    d.opt1   = stack_bus_pkg::SIMD_RELU_CMD;
    d.value1 = c.simd_cmd;
    return d;
  endfunction

  function automatic stack_bus_pkg::oob_data_t second_data(input oob_cmd_pkg::oob_cmd_t c);
    stack_bus_pkg::oob_data_t d;
    d.opt0   = stack_bus_pkg::TAG;
    d.value0 = c.tag;
    d.opt1   = stack_bus_pkg::NUM_LANES;
    d.value1 = c.num_lanes;
    return d;
  endfunction

  always_comb
  begin
    exp_first  = first_data(exp_cmd);
    exp_second = second_data(exp_cmd);
  end

  assign som_beat = oob_valid && (oob.cntl == stack_bus_pkg::SOM);
  assign eom_beat = oob_valid && (oob.cntl == stack_bus_pkg::EOM);

  task automatic refresh_expected();
    pending = ref_q.size();
    if (ref_q.size() != 0)
      exp_cmd = ref_q[0];
  endtask

  // Retire a packet one cycle after its EOM beat was checked
  always @(negedge clk)
  begin
    if (prev_eom && ref_q.size() != 0)
    begin
      ref_q.delete(0);
      refresh_expected();
    end
    prev_eom = eom_beat;
  end

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------

  a_reset_values: assert property (@(posedge clk)
    reset_checked && !$past(rst_n) |-> !cmd_ready && !oob_valid && !seq_error && oob == '0)
    else stop_on_error($sformatf(
      "** Error: reset cmd_ready/oob_valid/seq_error/oob expected 0 got %h %h %h %h",
      $sampled(cmd_ready), $sampled(oob_valid), $sampled(seq_error), $sampled(oob)));

  a_quiet_before_cmd: assert property (@(posedge clk) disable iff (!rst_n)
    !any_sent |-> !oob_valid && !seq_error)
    else stop_on_error($sformatf("** Error: oob_valid/seq_error expected 0 got %h %h",
      $sampled(oob_valid), $sampled(seq_error)));

  a_idle_beat: assert property (@(posedge clk) disable iff (!rst_n)
    !oob_valid |-> oob == '0)
    else stop_on_error($sformatf("** Error: oob expected 0 got %h", $sampled(oob)));

  a_beat_type: assert property (@(posedge clk) disable iff (!rst_n)
    oob_valid |-> oob.pkt_type == stack_bus_pkg::PE_OP_CMD)
    else stop_on_error($sformatf("** Error: oob.pkt_type expected %h got %h",
      stack_bus_pkg::PE_OP_CMD, $sampled(oob.pkt_type)));

  a_beat_cntl: assert property (@(posedge clk) disable iff (!rst_n)
    oob_valid |-> som_beat || eom_beat)
    else stop_on_error($sformatf("** Error: oob.cntl expected %h or %h got %h",
      stack_bus_pkg::SOM, stack_bus_pkg::EOM, $sampled(oob.cntl)));

  a_som_expected: assert property (@(posedge clk) disable iff (!rst_n)
    som_beat |-> pending != 0)
    else stop_on_error("A SOM beat appeared with no command outstanding");

  a_som_data: assert property (@(posedge clk) disable iff (!rst_n)
    som_beat |-> oob.data == exp_first)
    else stop_on_error($sformatf("** Error: oob.data (SOM) expected %h got %h",
      exp_first, $sampled(oob.data)));

  a_eom_data: assert property (@(posedge clk) disable iff (!rst_n)
    eom_beat |-> oob.data == exp_second)
    else stop_on_error($sformatf("** Error: oob.data (EOM) expected %h got %h",
      exp_second, $sampled(oob.data)));

  a_eom_follows: assert property (@(posedge clk) disable iff (!rst_n)
    $past(som_beat) |-> eom_beat)
    else stop_on_error($sformatf("** Error: oob.cntl after SOM expected %h got %h",
      stack_bus_pkg::EOM, $sampled(oob.cntl)));

  a_eom_after_som: assert property (@(posedge clk) disable iff (!rst_n)
    eom_beat |-> $past(som_beat))
    else stop_on_error("An EOM beat appeared without a SOM beat before it");

  a_packet_gap: assert property (@(posedge clk) disable iff (!rst_n)
    som_beat |-> !$past(oob_valid))
    else stop_on_error("** Error: oob_valid before SOM expected 0 got 1");

  // Registered ready, the state register and the output register
  a_ready_start: assert property (@(posedge clk) disable iff (!rst_n)
    som_beat |-> $past(oob_ready, 3))
    else stop_on_error("** Error: oob_ready before SOM expected 1 got 0");

  a_error_cause: assert property (@(posedge clk) disable iff (!rst_n)
    seq_error |-> bad_sent)
    else stop_on_error("** Error: seq_error expected 0 got 1");

  a_error_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    $past(seq_error) |-> seq_error)
    else stop_on_error("** Error: seq_error expected 1 got 0");

  a_error_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    seq_error |-> !oob_valid)
    else stop_on_error("** Error: oob_valid in error state expected 0 got 1");

  // ------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------

  function automatic oob_cmd_pkg::oob_cmd_t random_cmd();
    oob_cmd_pkg::oob_cmd_t c;
    logic [31:0]           r;
    r           = $urandom();
    c.cntl      = stack_bus_pkg::SOM_EOM;
    c.tag       = r[7:0];
    c.num_lanes = r[15:8];
    c.stop_cmd  = r[23:16];
    c.simd_cmd  = r[31:24];
    return c;
  endfunction

  task automatic drive_cmd(input oob_cmd_pkg::oob_cmd_t c, input bit track);
    cmd_valid = 1'b1;
    cmd       = c;
    any_sent  = 1'b1;
    if (track)
    begin
      ref_q.push_back(c);
      refresh_expected();
    end
  endtask

  task automatic drive_idle();
    cmd_valid = 1'b0;
  endtask

  // Idle the decoder until every sent command has left as a packet
  task automatic drain(input bit random_ready);
    logic [31:0] r;
    do
    begin
      @(negedge clk);
      drive_idle();
      if (random_ready)
      begin
        r         = $urandom();
        oob_ready = r[0];
      end
    end while (pending != 0);
  endtask

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_on_error("Watchdog expired, the run hung");
  end

  initial
  begin
    oob_cmd_pkg::oob_cmd_t  bad;
    logic [31:0]            rnd;
    int                     sent;
    rnd           = $urandom(SEED);
    rst_n         = 1'b0;
    cmd_valid     = 1'b0;
    cmd           = '0;
    oob_ready     = 1'b0;
    exp_cmd       = '0;
    pending       = 0;
    any_sent      = 1'b0;
    bad_sent      = 1'b0;
    reset_checked = 1'b0;
    prev_eom      = 1'b0;
    saw_ready_low = 1'b0;

    @(negedge clk);
    reset_checked = 1'b1;
    repeat (9) @(negedge clk);
    rst_n = 1'b1;
    while (!cmd_ready)
      @(negedge clk);

    // Single commands, one packet at a time
    oob_ready = 1'b1;
    for (int i = 0; i < N_SINGLE; i++)
    begin
      @(negedge clk);
      drive_cmd(random_cmd(), 1'b1);
      drain(1'b0);
    end

    // Full-rate burst against a stalled bus
    @(negedge clk);
    oob_ready = 1'b0;
    sent = 0;
    while (sent < N_BURST)
    begin
      @(negedge clk);
      if (cmd_ready)
      begin
        drive_cmd(random_cmd(), 1'b1);
        sent++;
      end
      else
      begin
        drive_idle();
        if (!saw_ready_low)
        begin
          saw_ready_low = 1'b1;
          repeat (20) @(negedge clk);
          oob_ready = 1'b1;
        end
      end
    end
    assert (saw_ready_low)
      else stop_on_error("cmd_ready never dropped during the full-rate burst");
    drain(1'b0);

    // Random bus ready and random gaps between commands
    sent = 0;
    while (sent < N_RANDOM)
    begin
      @(negedge clk);
      rnd       = $urandom();
      oob_ready = rnd[0];
      if (cmd_ready && rnd[1])
      begin
        drive_cmd(random_cmd(), 1'b1);
        sent++;
      end
      else
        drive_idle();
    end
    drain(1'b1);

    // SOM-only framing locks the sequencer
    @(negedge clk);
    oob_ready = 1'b1;
    bad       = random_cmd();
    bad.cntl  = stack_bus_pkg::SOM;
    drive_cmd(bad, 1'b0);
    bad_sent = 1'b1;
    do
    begin
      @(negedge clk);
      drive_idle();
    end while (!seq_error);
    repeat (30) @(negedge clk);

    $display("all tests passed");
    $finish;
  end

endmodule

/* bench/tb_clock.sv */
// Free-running clock for the OOB downstream testbench.

module tb_clock #(
  parameter int PERIOD = 4
) (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever
      #(PERIOD / 2) clk = ~clk;
  end

endmodule

/* hw/oob_downstream_top.sv */
// OOB downstream controller top level.
// Command queue feeding the stack bus packet sequencer.

module oob_downstream_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     cmd_valid,
  input  oob_cmd_pkg::oob_cmd_t    cmd,
  output logic                     cmd_ready,
  output logic                     oob_valid,
  output stack_bus_pkg::oob_beat_t oob,
  input  logic                     oob_ready,
  output logic                     seq_error
);

  // Queue head toward the sequencer
  logic                   head_valid;
  oob_cmd_pkg::oob_cmd_t  head;
  logic                   head_pop;

  oob_cmd_queue u_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .cmd_ready  (cmd_ready),
    .head_valid (head_valid),
    .head       (head),
    .head_pop   (head_pop)
  );

  oob_packet_seq u_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .head_valid (head_valid),
    .head       (head),
    .head_pop   (head_pop),
    .oob_valid  (oob_valid),
    .oob        (oob),
    .oob_ready  (oob_ready),
    .seq_error  (seq_error)
  );

endmodule

/* hw/oob_packet_seq.sv */
// Packet sequencer for the OOB downstream stack bus.
// Turns each queued command into a SOM/EOM beat pair, holds an error
// state on bad framing, and drives registered bus outputs.

module oob_packet_seq (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     head_valid,
  input  oob_cmd_pkg::oob_cmd_t    head,
  output logic                     head_pop,
  output logic                     oob_valid,
  output stack_bus_pkg::oob_beat_t oob,
  input  logic                     oob_ready,
  output logic                     seq_error
);

  oob_cmd_pkg::seq_state_t    state;
  oob_cmd_pkg::seq_state_t    state_next;
  logic                       oob_ready_q;
  logic                       valid_next;
  stack_bus_pkg::oob_beat_t   beat_next;

  // ------------------------------------------------------------------
  // State machine
  // ------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state       <= oob_cmd_pkg::WAIT;
      oob_ready_q <= 1'b0;
    end
    else
    begin
      state       <= state_next;
      oob_ready_q <= oob_ready;
    end
  end

  always_comb
  begin
    state_next = state;
    case (state)
      oob_cmd_pkg::WAIT:
      begin
        // Only single-beat commands are legal from the decoder
        if (head_valid && oob_ready_q)
        begin
          if (head.cntl == stack_bus_pkg::SOM_EOM)
            state_next = oob_cmd_pkg::START_PKT;
          else
            state_next = oob_cmd_pkg::ERR;
        end
      end
      oob_cmd_pkg::START_PKT:
        state_next = oob_cmd_pkg::SECOND_BEAT;
      oob_cmd_pkg::SECOND_BEAT:
        state_next = oob_cmd_pkg::WAIT;
      oob_cmd_pkg::ERR:
        state_next = oob_cmd_pkg::ERR;
      default:
        state_next = oob_cmd_pkg::WAIT;
    endcase
  end

  // Head is retired on the last beat
  assign head_pop = (state == oob_cmd_pkg::SECOND_BEAT);

  // ------------------------------------------------------------------
  // Beat formation
  // ------------------------------------------------------------------

  always_comb
  begin
    valid_next = 1'b0;
    beat_next  = '0;
    case (state)
      oob_cmd_pkg::START_PKT:
      begin
        valid_next                = 1'b1;
        beat_next.cntl            = stack_bus_pkg::SOM;
        beat_next.pkt_type        = stack_bus_pkg::PE_OP_CMD;
        beat_next.data.opt0       = stack_bus_pkg::STOP_CMD;
        beat_next.data.value0     = head.stop_cmd;
        beat_next.data.opt1       = stack_bus_pkg::SIMD_RELU_CMD;
        beat_next.data.value1     = head.simd_cmd;
      end
      oob_cmd_pkg::SECOND_BEAT:
      begin
        valid_next                = 1'b1;
        beat_next.cntl            = stack_bus_pkg::EOM;
        beat_next.pkt_type        = stack_bus_pkg::PE_OP_CMD;
        beat_next.data.opt0       = stack_bus_pkg::TAG;
        beat_next.data.value0     = head.tag;
        beat_next.data.opt1       = stack_bus_pkg::NUM_LANES;
        beat_next.data.value1     = head.num_lanes;
      end
      default:
      begin
        // Idle beat is MOM / NA / NOP with zero values
        beat_next.cntl            = stack_bus_pkg::MOM;
        beat_next.pkt_type        = stack_bus_pkg::NA;
        beat_next.data.opt0       = stack_bus_pkg::NOP;
        beat_next.data.opt1       = stack_bus_pkg::NOP;
      end
    endcase
  end

  // Registered bus outputs
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      oob_valid <= 1'b0;
      oob       <= '0;
      seq_error <= 1'b0;
    end
    else
    begin
      oob_valid <= valid_next;
      oob       <= beat_next;
      seq_error <= (state == oob_cmd_pkg::ERR);
    end
  end

endmodule

/* hw/oob_cmd_queue.sv */
// Command queue for the OOB downstream controller.
// Registers decoder commands into a circular FIFO with an almost-full
// ready, and keeps a two-stage read pipeline charged toward the sequencer.

module oob_cmd_queue (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cmd_valid,
  input  oob_cmd_pkg::oob_cmd_t  cmd,
  output logic                   cmd_ready,
  output logic                   head_valid,
  output oob_cmd_pkg::oob_cmd_t  head,
  input  logic                   head_pop
);

  // ------------------------------------------------------------------
  // Input register
  // ------------------------------------------------------------------

  logic                   in_valid;
  oob_cmd_pkg::oob_cmd_t  in_cmd;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      in_valid <= 1'b0;
    else
      in_valid <= cmd_valid;
  end

  always_ff @(posedge clk)
  begin
    in_cmd <= cmd;
  end

  // ------------------------------------------------------------------
  // Circular FIFO storage
  // ------------------------------------------------------------------

  oob_cmd_pkg::oob_cmd_t  mem [oob_cmd_pkg::QUEUE_DEPTH];
  oob_cmd_pkg::ptr_t      wr_ptr;
  oob_cmd_pkg::ptr_t      rd_ptr;
  oob_cmd_pkg::count_t    count;
  logic                   fifo_write;
  logic                   fifo_read;

  // FIFO output stage and pipe stage
  logic                   fifo_out_valid;
  oob_cmd_pkg::oob_cmd_t  fifo_out_cmd;
  logic                   fifo_out_read;
  logic                   pipe_valid;
  oob_cmd_pkg::oob_cmd_t  pipe_cmd;

  assign fifo_write = in_valid;

  // Pull from memory whenever the output stage is empty or moving on
  assign fifo_read     = (count != '0) && (!fifo_out_valid || fifo_out_read);
  assign fifo_out_read = fifo_out_valid && (!pipe_valid || head_pop);

  always_ff @(posedge clk)
  begin
    if (fifo_write)
      mem[wr_ptr] <= in_cmd;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (fifo_write)
        wr_ptr <= wr_ptr + 1'b1;
      if (fifo_read)
        rd_ptr <= rd_ptr + 1'b1;
      if (fifo_write && !fifo_read)
        count <= count + 1'b1;
      else if (!fifo_write && fifo_read)
        count <= count - 1'b1;
    end
  end

  // Almost-full ready, one cycle behind the count
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      cmd_ready <= 1'b0;
    else
      cmd_ready <= count < oob_cmd_pkg::count_t'(oob_cmd_pkg::QUEUE_THRESHOLD);
  end

  // ------------------------------------------------------------------
  // Read pipeline
  // ------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      fifo_out_valid <= 1'b0;
      pipe_valid     <= 1'b0;
    end
    else
    begin
      if (fifo_read)
        fifo_out_valid <= 1'b1;
      else if (fifo_out_read)
        fifo_out_valid <= 1'b0;

      if (fifo_out_read)
        pipe_valid <= 1'b1;
      else if (head_pop)
        pipe_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (fifo_read)
      fifo_out_cmd <= mem[rd_ptr];
    if (fifo_out_read)
      pipe_cmd <= fifo_out_cmd;
  end

  assign head_valid = pipe_valid;
  assign head       = pipe_cmd;

endmodule

/* hw/oob_cmd_pkg.sv */
// Work-unit decoder command definitions for the OOB controller.
// Field widths, command layout, queue sizing and sequencer states.

package oob_cmd_pkg;

  // ------------------------------------------------------------------
  // Command fields
  // ------------------------------------------------------------------

  localparam int TAG_W       = 8;
  localparam int LANES_W     = 8;
  localparam int OPT_VALUE_W = 8;

  // Single-beat command from the decoder
  typedef struct packed {
    stack_bus_pkg::cntl_t     cntl;
    logic [TAG_W-1:0]         tag;
    logic [LANES_W-1:0]       num_lanes;
    logic [OPT_VALUE_W-1:0]   stop_cmd;
    logic [OPT_VALUE_W-1:0]   simd_cmd;
  } oob_cmd_t;

  // ------------------------------------------------------------------
  // Command queue sizing
  // ------------------------------------------------------------------

  localparam int QUEUE_DEPTH     = 8;
  // Leaves room for commands already in flight when ready drops
  localparam int QUEUE_THRESHOLD = 5;
  localparam int QUEUE_AW        = $clog2(QUEUE_DEPTH);
  localparam int QUEUE_CW        = $clog2(QUEUE_DEPTH + 1);

  typedef logic [QUEUE_AW-1:0] ptr_t;
  typedef logic [QUEUE_CW-1:0] count_t;

  // Packet sequencer states
  typedef enum logic [1:0] {
    WAIT        = 2'd0,
    START_PKT   = 2'd1,
    SECOND_BEAT = 2'd2,
    ERR         = 2'd3
  } seq_state_t;

endpackage

/* hw/stack_bus_pkg.sv */
// Stack bus definitions for the OOB downstream channel.
// Framing codes, packet types, option codes and the beat layout.

package stack_bus_pkg;

  // ------------------------------------------------------------------
  // Message framing
  // ------------------------------------------------------------------

  typedef enum logic [1:0] {
    MOM     = 2'd0,
    SOM     = 2'd1,
    EOM     = 2'd2,
    SOM_EOM = 2'd3
  } cntl_t;

  // ------------------------------------------------------------------
  // OOB packet type and option codes
  // ------------------------------------------------------------------

  typedef enum logic [1:0] {
    NA        = 2'd0,
    PE_OP_CMD = 2'd1
  } oob_type_t;

  typedef enum logic [3:0] {
    NOP           = 4'd0,
    STOP_CMD      = 4'd1,
    SIMD_RELU_CMD = 4'd2,
    TAG           = 4'd3,
    NUM_LANES     = 4'd4
  } oob_opt_t;

  localparam int OOB_VALUE_W = 8;

  // Two labelled values per beat, opt0 in the upper bits
  typedef struct packed {
    oob_opt_t                 opt0;
    logic [OOB_VALUE_W-1:0]   value0;
    oob_opt_t                 opt1;
    logic [OOB_VALUE_W-1:0]   value1;
  } oob_data_t;

  // One bus beat (type is a keyword, hence pkt_type)
  typedef struct packed {
    cntl_t      cntl;
    oob_type_t  pkt_type;
    oob_data_t  data;
  } oob_beat_t;

endpackage
